// ==== frontend_top.f ====
+incdir+.
procyon_types.sv
lane_if.sv
sync_fifo.sv
fetch.sv
dispatch_steer.sv
decode_lane.sv
retire_merge.sv
frontend_top.sv
tb_clock.sv
tb_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f frontend_top.f --top-module tb_frontend -o tb_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_frontend)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
else
    exit 1
fi

// ==== tb_frontend.sv ====
// Front end testbench
module tb_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 20000;                // Run needs about 2000 cycles

    logic                          clk;
    logic                          n_rst;
    logic                          i_redirect;
    procyon_types::procyon_addr_t  i_redirect_addr;
    procyon_types::procyon_data_t  i_insn;
    logic                          i_data_valid;
    procyon_types::procyon_addr_t  o_pc;
    logic                          o_en;
    logic                          i_retire_stall;
    logic                          o_retire_valid;
    procyon_types::procyon_addr_t  o_retire_pc;
    procyon_types::procyon_class_t o_retire_class;
    logic [4:0]                    o_retire_rd;
    logic [4:0]                    o_retire_rs1;
    logic [4:0]                    o_retire_rs2;
    procyon_types::procyon_data_t  o_retire_imm;

    logic [31:0]                   mem [MEM_WORDS];
    procyon_types::procyon_addr_t  req_pc = '0;           // Request seen by the memory
    logic                          req_en = 1'b0;
    procyon_types::procyon_addr_t  exp_pc = '0;
    logic [48:0]                   exp_dec;
    int unsigned                   drop_pct = 0;
    int unsigned                   stall_pct = 0;
    int unsigned                   retired = 0;
    int unsigned                   full_cycles = 0;
    int unsigned                   class_seen [4] = '{default: 0};
    int unsigned                   cycles = 0;
    string                         test_name = "reset";

    tb_clock #(.PERIOD(8), .RESET_CYCLES(16)) u_clock (
        .clk(clk),
        .n_rst(n_rst)
    );

    frontend_top DUT (
        .clk(clk),
        .n_rst(n_rst),
        .i_redirect(i_redirect),
        .i_redirect_addr(i_redirect_addr),
        .i_insn(i_insn),
        .i_data_valid(i_data_valid),
        .o_pc(o_pc),
        .o_en(o_en),
        .i_retire_stall(i_retire_stall),
        .o_retire_valid(o_retire_valid),
        .o_retire_pc(o_retire_pc),
        .o_retire_class(o_retire_class),
        .o_retire_rd(o_retire_rd),
        .o_retire_rs1(o_retire_rs1),
        .o_retire_rs2(o_retire_rs2),
        .o_retire_imm(o_retire_imm)
    );

    // Expected {class, rd, rs1, rs2, imm} of one word
    function automatic logic [48:0] ref_decode(input logic [31:0] word);
        logic [1:0]  cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        cls = procyon_types::class_illegal;
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        case (word[6:0])
            7'b0110011: begin
                cls = procyon_types::class_reg_alu;
                rd  = word[11:7];
                rs1 = word[19:15];
                rs2 = word[24:20];
            end
            7'b0010011, 7'b0000011: begin
                cls = (word[6:0] == 7'b0000011) ? procyon_types::class_load
                                                : procyon_types::class_imm_alu;
                rd  = word[11:7];
                rs1 = word[19:15];
                imm = {{20{word[31]}}, word[31:20]};
            end
            default: ;
        endcase
        return {cls, rd, rs1, rs2, imm};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "Mismatch in test %s", test_name);
        end
    endtask

    task automatic wait_retired(input int unsigned count);
        int unsigned target;
        target = retired + count;
        while (retired < target) @(negedge clk);
    endtask

    // Memory sees the request on the edge, answers a cycle later
    always @(negedge clk) begin
        req_pc = o_pc;
        req_en = o_en;
    end

    always @(posedge clk) begin
        #1;
        i_insn         = mem[req_pc[9:2]];
        i_data_valid   = req_en && ($urandom_range(99) >= drop_pct);
        i_retire_stall = n_rst && ($urandom_range(99) < stall_pct);
    end

    // Compare every retired instruction against the expected stream
    always @(negedge clk) begin
        if (!n_rst) begin
            check_value("retire valid", 32'd0, 32'(o_retire_valid));
            check_value("pc", 32'd0, o_pc);
        end else begin
            if (!i_redirect) check_value("fetch enable", 32'd1, 32'(o_en));
            if (o_retire_valid) begin
                exp_dec = ref_decode(mem[exp_pc[9:2]]);
                check_value("retire pc", exp_pc, o_retire_pc);
                check_value("class", 32'(exp_dec[48:47]), 32'(o_retire_class));
                check_value("rd", 32'(exp_dec[46:42]), 32'(o_retire_rd));
                check_value("rs1", 32'(exp_dec[41:37]), 32'(o_retire_rs1));
                check_value("rs2", 32'(exp_dec[36:32]), 32'(o_retire_rs2));
                check_value("imm", exp_dec[31:0], o_retire_imm);
                class_seen[exp_dec[48:47]]++;
                exp_pc = exp_pc + 32'd4;
                retired++;
            end
            if (i_redirect) exp_pc = i_redirect_addr;     // Same-cycle output was old path
            if (DUT.u_fetch.fifo_full) full_cycles++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic [31:0] word;
        int unsigned kind;
        int unsigned full_before;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        i_insn          = '0;
        i_data_valid    = 1'b0;
        i_retire_stall  = 1'b0;
        void'($urandom(31442));

        // Random words with the opcode forced to one of four kinds
        for (int i = 0; i < MEM_WORDS; i++) begin
            kind = $urandom_range(3);
            word = $urandom;
            case (kind)
                0: word[6:0] = 7'b0110011;
                1: word[6:0] = 7'b0010011;
                2: word[6:0] = 7'b0000011;
                default: begin
                    while (word[6:0] == 7'b0110011 || word[6:0] == 7'b0010011 ||
                           word[6:0] == 7'b0000011) begin
                        word[6:0] = 7'($urandom);
                    end
                end
            endcase
            mem[i] = word;
        end

        wait (n_rst === 1'b1);

        test_name = "sequential";
        wait_retired(200);

        test_name = "bubbles";
        drop_pct  = 40;
        wait_retired(200);

        test_name   = "backpressure";
        drop_pct    = 0;
        stall_pct   = 70;
        full_before = full_cycles;
        wait_retired(200);
        check_value("fifo filled", 32'd1, 32'(full_cycles > full_before));

        test_name = "redirect";
        drop_pct  = 20;
        stall_pct = 30;
        repeat (12) begin
            @(posedge clk);
            #1;
            i_redirect      = 1'b1;
            i_redirect_addr = $urandom & 32'hFFFF_FFFC;
            @(posedge clk);
            #1;
            i_redirect = 1'b0;
            wait_retired($urandom_range(12, 1));          // First one must be the target
            repeat ($urandom_range(6)) @(posedge clk);
        end
        wait_retired(100);

        test_name = "illegal words";
        check_value("reg alu seen", 32'd1, 32'(class_seen[0] > 0));
        check_value("imm alu seen", 32'd1, 32'(class_seen[1] > 0));
        check_value("load seen", 32'd1, 32'(class_seen[2] > 0));
        check_value("illegal seen", 32'd1, 32'(class_seen[3] > 0));

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic n_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 n_rst = 1'b1;                                  // Released just after an edge
    end

endmodule

// ==== frontend_top.sv ====
// Instruction front end
`include "procyon_cfg.svh"

module frontend_top (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic                          i_redirect,
    input  procyon_types::procyon_addr_t  i_redirect_addr,

    input  procyon_types::procyon_data_t  i_insn,
    input  logic                          i_data_valid,
    output procyon_types::procyon_addr_t  o_pc,
    output logic                          o_en,

    input  logic                          i_retire_stall,
    output logic                          o_retire_valid,
    output procyon_types::procyon_addr_t  o_retire_pc,
    output procyon_types::procyon_class_t o_retire_class,
    output logic [4:0]                    o_retire_rd,
    output logic [4:0]                    o_retire_rs1,
    output logic [4:0]                    o_retire_rs2,
    output procyon_types::procyon_data_t  o_retire_imm
);

    procyon_types::procyon_addr_t dispatch_pc;
    procyon_types::procyon_data_t dispatch_insn;
    logic                         dispatch_valid;
    logic                         dispatch_stall;

    lane_if lane_bus [`DECODE_LANES] ();

    fetch u_fetch (
        .clk(clk),
        .n_rst(n_rst),
        .i_redirect(i_redirect),
        .i_redirect_addr(i_redirect_addr),
        .i_insn(i_insn),
        .i_data_valid(i_data_valid),
        .o_pc(o_pc),
        .o_en(o_en),
        .i_dispatch_stall(dispatch_stall),
        .o_dispatch_pc(dispatch_pc),
        .o_dispatch_insn(dispatch_insn),
        .o_dispatch_valid(dispatch_valid)
    );

    dispatch_steer u_steer (
        .clk(clk),
        .n_rst(n_rst),
        .i_redirect(i_redirect),
        .i_valid(dispatch_valid),
        .i_pc(dispatch_pc),
        .i_insn(dispatch_insn),
        .o_stall(dispatch_stall),
        .lanes(lane_bus)
    );

    for (genvar g = 0; g < `DECODE_LANES; g++) begin : g_lanes
        decode_lane u_lane (
            .clk(clk),
            .n_rst(n_rst),
            .i_redirect(i_redirect),
            .lane(lane_bus[g])
        );
    end

    retire_merge u_merge (
        .clk(clk),
        .n_rst(n_rst),
        .i_redirect(i_redirect),
        .i_retire_stall(i_retire_stall),
        .lanes(lane_bus),
        .o_retire_valid(o_retire_valid),
        .o_retire_pc(o_retire_pc),
        .o_retire_class(o_retire_class),
        .o_retire_rd(o_retire_rd),
        .o_retire_rs1(o_retire_rs1),
        .o_retire_rs2(o_retire_rs2),
        .o_retire_imm(o_retire_imm)
    );

endmodule

// ==== retire_merge.sv ====
// In-order retire merge
`include "procyon_cfg.svh"

module retire_merge (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic                          i_redirect,
    input  logic                          i_retire_stall,

    lane_if.merge                         lanes [`DECODE_LANES],

    output logic                          o_retire_valid,
    output procyon_types::procyon_addr_t  o_retire_pc,
    output procyon_types::procyon_class_t o_retire_class,
    output logic [4:0]                    o_retire_rd,
    output logic [4:0]                    o_retire_rs1,
    output logic [4:0]                    o_retire_rs2,
    output procyon_types::procyon_data_t  o_retire_imm
);

    localparam int LANE_W = $clog2(`DECODE_LANES);

    logic [LANE_W-1:0]            lane_ptr;                // Follows the steering order
    logic [`DECODE_LANES-1:0]     res_valid;
    procyon_types::procyon_addr_t res_pc [`DECODE_LANES];
    procyon_types::procyon_dec_t  res_dec [`DECODE_LANES];
    procyon_types::procyon_dec_t  head_dec;

    for (genvar g = 0; g < `DECODE_LANES; g++) begin : g_lane
        assign res_valid[g]  = lanes[g].res_valid;
        assign res_pc[g]     = lanes[g].res_pc;
        assign res_dec[g]    = lanes[g].res_dec;
        assign lanes[g].take = o_retire_valid & (lane_ptr == LANE_W'(g));

        a_take_valid: assert property (@(posedge clk) disable iff (~n_rst)
            lanes[g].take |-> lanes[g].res_valid && !i_retire_stall)
            else $error("retire_merge: take from empty lane %0d", g);
    end

    assign o_retire_valid = res_valid[lane_ptr] & ~i_retire_stall;
    assign o_retire_pc    = res_pc[lane_ptr];
    assign head_dec       = res_dec[lane_ptr];
    assign o_retire_class = head_dec.insn_class;
    assign o_retire_rd    = head_dec.rd;
    assign o_retire_rs1   = head_dec.rs1;
    assign o_retire_rs2   = head_dec.rs2;
    assign o_retire_imm   = head_dec.imm;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            lane_ptr <= '0;
        end else if (i_redirect) begin
            lane_ptr <= '0;
        end else if (o_retire_valid) begin
            lane_ptr <= (lane_ptr == LANE_W'(`DECODE_LANES - 1)) ? '0 : lane_ptr + 1'b1;
        end
    end

endmodule

// ==== decode_lane.sv ====
// Predecode lane
`include "procyon_cfg.svh"

module decode_lane (
    input  logic clk,
    input  logic n_rst,

    input  logic i_redirect,

    lane_if.lane lane
);

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;

    procyon_types::procyon_insn_t insn;
    procyon_types::procyon_dec_t  dec;
    procyon_types::procyon_dec_t  dec_q;
    procyon_types::procyon_addr_t pc_q;
    logic                         valid_q;

    assign insn = lane.issue_insn;

    always_comb begin
        dec = '0;
        case (insn.r.opcode)
            OPCODE_OP: begin
                dec.insn_class = procyon_types::class_reg_alu;
                dec.rd         = insn.r.rd;
                dec.rs1        = insn.r.rs1;
                dec.rs2        = insn.r.rs2;
            end
            OPCODE_OP_IMM, OPCODE_LOAD: begin
                dec.insn_class = (insn.i.opcode == OPCODE_LOAD) ? procyon_types::class_load
                                                                : procyon_types::class_imm_alu;
                dec.rd         = insn.i.rd;
                dec.rs1        = insn.i.rs1;
                dec.imm        = {{(`DATA_WIDTH - 12){insn.i.imm12[11]}}, insn.i.imm12};
            end
            default: begin
                dec.insn_class = procyon_types::class_illegal;  // Fields stay zero
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_q <= 1'b0;
        end else if (i_redirect) begin
            valid_q <= 1'b0;
        end else if (lane.issue_valid) begin
            valid_q <= 1'b1;                              // Refill wins over take
        end else if (lane.take) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lane.issue_valid) begin
            pc_q  <= lane.issue_pc;
            dec_q <= dec;
        end
    end

    assign lane.busy      = valid_q;
    assign lane.res_valid = valid_q;
    assign lane.res_pc    = pc_q;
    assign lane.res_dec   = dec_q;

    // A result comes from an issue or is still held from the last cycle
    a_res_from_issue: assert property (@(posedge clk) disable iff (~n_rst)
        lane.res_valid |-> $past(lane.issue_valid) || $past(lane.res_valid && !lane.take))
        else $error("decode_lane: result without issue");

endmodule

// ==== dispatch_steer.sv ====
// Round-robin lane steering
`include "procyon_cfg.svh"

module dispatch_steer (
    input  logic                         clk,
    input  logic                         n_rst,

    input  logic                         i_redirect,
    input  logic                         i_valid,
    input  procyon_types::procyon_addr_t i_pc,
    input  procyon_types::procyon_data_t i_insn,
    output logic                         o_stall,

    lane_if.steer                        lanes [`DECODE_LANES]
);

    localparam int LANE_W = $clog2(`DECODE_LANES);

    logic [LANE_W-1:0]        lane_ptr;
    logic [`DECODE_LANES-1:0] lane_free;
    logic                     issue;

    assign issue   = i_valid & lane_free[lane_ptr] & ~i_redirect;
    assign o_stall = ~lane_free[lane_ptr];               // Holds the FIFO head

    for (genvar g = 0; g < `DECODE_LANES; g++) begin : g_lane
        assign lane_free[g]         = ~lanes[g].busy | lanes[g].take;
        assign lanes[g].issue_valid = issue & (lane_ptr == LANE_W'(g));
        assign lanes[g].issue_pc    = i_pc;
        assign lanes[g].issue_insn  = i_insn;

        // Entry must be empty or leaving through merge
        a_issue_free: assert property (@(posedge clk) disable iff (~n_rst)
            lanes[g].issue_valid |-> !lanes[g].busy || lanes[g].take)
            else $error("dispatch_steer: issue to occupied lane %0d", g);
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            lane_ptr <= '0;
        end else if (i_redirect) begin
            lane_ptr <= '0;
        end else if (issue) begin
            lane_ptr <= (lane_ptr == LANE_W'(`DECODE_LANES - 1)) ? '0 : lane_ptr + 1'b1;
        end
    end

endmodule

// ==== fetch.sv ====
// Instruction fetch
`include "procyon_cfg.svh"

module fetch (
    input  logic                         clk,
    input  logic                         n_rst,

    input  logic                         i_redirect,
    input  procyon_types::procyon_addr_t i_redirect_addr,

    // Instruction memory port
    input  procyon_types::procyon_data_t i_insn,
    input  logic                         i_data_valid,
    output procyon_types::procyon_addr_t o_pc,
    output logic                         o_en,

    // Toward steering
    input  logic                         i_dispatch_stall,
    output procyon_types::procyon_addr_t o_dispatch_pc,
    output procyon_types::procyon_data_t o_dispatch_insn,
    output logic                         o_dispatch_valid
);

    procyon_types::procyon_addr_t      pc;               // Address the memory answers now
    procyon_types::procyon_addr_t      pc_plus_4;
    procyon_types::procyon_addr_t      next_pc;
    procyon_types::procyon_addr_data_t fifo_data_i;
    procyon_types::procyon_addr_data_t fifo_data_o;
    logic                              req_pend;
    logic                              accept;
    logic                              fifo_full;

    assign accept    = req_pend & i_data_valid & ~fifo_full;
    assign pc_plus_4 = pc + `ADDR_WIDTH'(4);

    // Hold, step or redirect
    always_comb begin
        case ({i_redirect, accept})
            2'b00:   next_pc = pc;                        // Missing word or full FIFO
            2'b01:   next_pc = pc_plus_4;
            default: next_pc = i_redirect_addr;
        endcase
    end

    assign o_pc = next_pc;
    assign o_en = ~i_redirect;

    assign fifo_data_i     = '{pc: pc, insn: i_insn};
    assign o_dispatch_pc   = fifo_data_o.pc;
    assign o_dispatch_insn = fifo_data_o.insn;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            pc       <= '0;
            req_pend <= 1'b0;
        end else begin
            pc       <= next_pc;
            req_pend <= o_en;                             // No answer expected after redirect
        end
    end

    sync_fifo #(
        .DATA_WIDTH($bits(procyon_types::procyon_addr_data_t)),
        .FIFO_DEPTH(`FETCH_FIFO_DEPTH)
    ) insn_fifo (
        .clk(clk),
        .n_rst(n_rst),
        .i_flush(i_redirect),
        .i_fifo_ack(~i_dispatch_stall),
        .o_fifo_data(fifo_data_o),
        .o_fifo_valid(o_dispatch_valid),
        .i_fifo_we(accept),
        .i_fifo_data(fifo_data_i),
        .o_fifo_full(fifo_full)
    );

endmodule

// ==== sync_fifo.sv ====
// Synchronous FIFO
module sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  n_rst,

    input  logic                  i_flush,
    input  logic                  i_fifo_ack,
    output logic [DATA_WIDTH-1:0] o_fifo_data,
    output logic                  o_fifo_valid,
    input  logic                  i_fifo_we,
    input  logic [DATA_WIDTH-1:0] i_fifo_data,
    output logic                  o_fifo_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] entries [FIFO_DEPTH];
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push         = i_fifo_we;
    assign pop          = i_fifo_ack & o_fifo_valid;
    assign o_fifo_valid = (count != '0);
    assign o_fifo_full  = (count == CNT_W'(FIFO_DEPTH));
    assign o_fifo_data  = entries[rd_ptr];               // Head shows without a read cycle

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            if (push & ~pop) count <= count + 1'b1;
            else if (pop & ~push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) entries[wr_ptr] <= i_fifo_data;
    end

    // The writer must watch the full flag
    a_no_overflow: assert property (@(posedge clk) disable iff (~n_rst)
        i_fifo_we && o_fifo_full |-> i_flush)
        else $error("sync_fifo: write while full");

endmodule

// ==== lane_if.sv ====
// Predecode lane bus
interface lane_if;

    logic                         issue_valid;
    procyon_types::procyon_addr_t issue_pc;
    procyon_types::procyon_data_t issue_insn;
    logic                         busy;
    logic                         res_valid;
    procyon_types::procyon_addr_t res_pc;
    procyon_types::procyon_dec_t  res_dec;
    logic                         take;

    modport steer (
        output issue_valid, issue_pc, issue_insn,
        input  busy, take
    );

    modport lane (
        input  issue_valid, issue_pc, issue_insn, take,
        output busy, res_valid, res_pc, res_dec
    );

    modport merge (
        input  res_valid, res_pc, res_dec,
        output take
    );

endinterface

// ==== procyon_types.sv ====
// Front end shared types
`include "procyon_cfg.svh"

package procyon_types;

    typedef logic [`ADDR_WIDTH-1:0] procyon_addr_t;
    typedef logic [`DATA_WIDTH-1:0] procyon_data_t;

    // One FIFO entry
    typedef struct packed {
        procyon_addr_t pc;
        procyon_data_t insn;
    } procyon_addr_data_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } procyon_rtype_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } procyon_itype_t;

    // Same word seen as R or I layout
    typedef union packed {
        procyon_rtype_t r;
        procyon_itype_t i;
    } procyon_insn_t;

    typedef enum logic [1:0] {
        class_reg_alu = 2'd0,
        class_imm_alu = 2'd1,
        class_load    = 2'd2,
        class_illegal = 2'd3
    } procyon_class_t;

    typedef struct packed {
        procyon_class_t insn_class;
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        procyon_data_t  imm;
    } procyon_dec_t;

endpackage

// ==== procyon_cfg.svh ====
// Front end configuration
`ifndef PROCYON_CFG_SVH
`define PROCYON_CFG_SVH

// PC width
`define ADDR_WIDTH 32

// Instruction word width
`define DATA_WIDTH 32

// Entries in the fetch FIFO
`define FETCH_FIFO_DEPTH 8

// Predecode lanes, two or more
`define DECODE_LANES 4

`endif
